// ==== source/tlbPkg.sv ====
////////////////////
// TLB shared definitions
// geometry and miss response constants
// request, response and entry types
////////////////////
package tlbPkg;

	// geometry for 4K pages only
	localparam int SetCount = 64;
	localparam int WayCount = 4;
	localparam int IndexWidth = 6;
	localparam int VirtWidth = 48;
	localparam int PageShift = 12;

	typedef logic [VirtWidth-1:0] VirtAddr;
	typedef logic [VirtWidth-PageShift-1:0] PageNum;
	typedef logic [IndexWidth-1:0] SetIndex;
	typedef logic [15:0] ExcCode;

	// loads and stores are the translating ops
	typedef enum logic [2:0]
	{
		OpNone = 3'd0,
		OpLoad = 3'd1,
		OpStore = 3'd2,
		OpLdtlb = 3'd3,
		OpInvtlb = 3'd4
	} MemOp;

	typedef enum logic [1:0]
	{
		OkReady = 2'd0,
		OkOk = 2'd1,
		OkHold = 2'd2
	} OkCode;

	typedef struct packed
	{
		PageNum virtPage;
		PageNum physPage;
		logic valid;
	} TlbEntry;

	// one whole set, way 0 most recently used
	typedef TlbEntry [WayCount-1:0] TlbSet;

	typedef struct packed
	{
		MemOp opm;
		VirtAddr addr;
		TlbEntry data;
	} TlbRequest;

	typedef struct packed
	{
		VirtAddr addr;
		MemOp opm;
		OkCode ok;
		ExcCode exc;
	} TlbResponse;

	// response on a miss
	localparam VirtAddr MissAddr = 48'h010000;
	localparam ExcCode MissExc = 16'hA001;
	localparam ExcCode NoExc = 16'h0000;

endpackage

// ==== source/tlbWayStore.sv ====
////////////////////
// TLB entry memory
// four ways per set, whole-set write
// set read registered with its index
////////////////////
module tlbWayStore
(
	input logic clock,
	input logic arstN,
	input tlbPkg::SetIndex readIndex,
	output tlbPkg::TlbSet storedSet,
	output tlbPkg::SetIndex heldIndex,
	input logic writeEnable,
	input tlbPkg::SetIndex writeIndex,
	input tlbPkg::TlbSet writeSet
);

	tlbPkg::TlbSet sets [tlbPkg::SetCount];

	// registered read returns old data on a same-edge write
	always_ff @(posedge clock)
	begin
		storedSet <= sets[readIndex];
		if (writeEnable)
		begin
			sets[writeIndex] <= writeSet;
		end
	end

	// index that goes with storedSet
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			heldIndex <= '0;
		end
		else
		begin
			heldIndex <= readIndex;
		end
	end

endmodule

// ==== source/tlbFlushMask.sv ====
////////////////////
// per-set invalidation mask
////////////////////
module tlbFlushMask
(
	input logic clock,
	input logic arstN,
	input logic flushAll,
	input logic clearEnable,
	input tlbPkg::SetIndex clearIndex,
	input tlbPkg::SetIndex heldIndex,
	output logic setFlushed
);

	logic [tlbPkg::SetCount-1:0] flushed;

	// invalidate-all wins over a set write
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			flushed <= '1;
		end
		else if (flushAll)
		begin
			flushed <= '1;
		end
		else if (clearEnable)
		begin
			flushed[clearIndex] <= 1'b0;
		end
	end

	assign setFlushed = flushed[heldIndex];

endmodule

// ==== source/tlbWayMatch.sv ====
////////////////////
// TLB way compare and hit select
// physical address forming
// MRU and load-entry set ordering
////////////////////
module tlbWayMatch
(
	input tlbPkg::TlbSet storedSet,
	input logic setFlushed,
	input tlbPkg::VirtAddr lookupAddr,
	input tlbPkg::TlbEntry newEntry,
	output logic [tlbPkg::WayCount-1:0] hitWay,
	output logic hit,
	output tlbPkg::VirtAddr physAddr,
	output tlbPkg::TlbSet reorderSet,
	output tlbPkg::TlbSet loadSet
);

	tlbPkg::TlbSet liveSet;
	tlbPkg::TlbEntry hitEntry;
	tlbPkg::PageNum lookupPage;
	logic [tlbPkg::WayCount-1:0] wayHit;
	logic earlierHit;
	logic shiftDown;

	assign lookupPage = lookupAddr[tlbPkg::VirtWidth-1:tlbPkg::PageShift];

	// flushed set reads as all invalid
	always_comb
	begin
		liveSet = storedSet;
		for (int w = 0; w < tlbPkg::WayCount; w++)
		begin
			if (setFlushed)
			begin
				liveSet[w].valid = 1'b0;
			end
			wayHit[w] = liveSet[w].valid && (liveSet[w].virtPage == lookupPage);
		end
	end

	// first matching way wins
	always_comb
	begin
		earlierHit = 1'b0;
		hitEntry = liveSet[0];
		for (int w = 0; w < tlbPkg::WayCount; w++)
		begin
			hitWay[w] = wayHit[w] && !earlierHit;
			if (hitWay[w])
			begin
				hitEntry = liveSet[w];
			end
			earlierHit = earlierHit | wayHit[w];
		end
	end

	assign hit = |wayHit;
	assign physAddr = {hitEntry.physPage, lookupAddr[tlbPkg::PageShift-1:0]};

	// hit way to the front with the ways ahead of it moved down one
	always_comb
	begin
		reorderSet = liveSet;
		shiftDown = 1'b0;
		for (int w = tlbPkg::WayCount - 1; w >= 1; w--)
		begin
			shiftDown = shiftDown | hitWay[w];
			if (shiftDown)
			begin
				reorderSet[w] = liveSet[w-1];
			end
		end
		if (shiftDown)
		begin
			reorderSet[0] = hitEntry;
		end
	end

	// insert at way 0 and drop the last way
	always_comb
	begin
		loadSet[0] = newEntry;
		for (int w = 1; w < tlbPkg::WayCount; w++)
		begin
			loadSet[w] = liveSet[w-1];
		end
	end

endmodule

// ==== source/tlbControl.sv ====
////////////////////
// TLB controller
// set hash, page readiness, write FSM
// bypass, miss handling, response register
////////////////////
module tlbControl
(
	input logic clock,
	input logic arstN,
	input tlbPkg::TlbRequest request,
	input logic mmuEnable,
	input tlbPkg::SetIndex heldIndex,
	input logic [tlbPkg::WayCount-1:0] hitWay,
	input logic hit,
	input tlbPkg::VirtAddr physAddr,
	input tlbPkg::TlbSet reorderSet,
	input tlbPkg::TlbSet loadSet,
	output tlbPkg::SetIndex readIndex,
	output tlbPkg::VirtAddr lookupAddr,
	output logic writeEnable,
	output tlbPkg::SetIndex writeIndex,
	output tlbPkg::TlbSet writeSet,
	output logic flushAll,
	output logic clearEnable,
	output tlbPkg::SetIndex clearIndex,
	output tlbPkg::TlbResponse response
);

	typedef enum logic [1:0]
	{
		Idle,
		Loaded,
		Reordered
	} CtrlState;

	CtrlState state;
	CtrlState nextState;
	tlbPkg::TlbRequest prevRequest;
	tlbPkg::TlbResponse nextResponse;
	logic pageReady;
	logic sameRequest;
	logic ioSpace;
	logic translateOn;
	logic isTranslate;

	function automatic tlbPkg::SetIndex setHash(input tlbPkg::VirtAddr addr);
		return addr[17:12] ^ addr[21:16];
	endfunction

	assign readIndex = setHash(request.addr);
	assign lookupAddr = prevRequest.addr;

	// held set and page match the current request
	assign pageReady = (heldIndex == readIndex) &&
		(prevRequest.addr[47:12] == request.addr[47:12]) &&
		(prevRequest.opm == request.opm);
	assign sameRequest = (request == prevRequest);

	// I/O window passes through untranslated
	assign ioSpace = (prevRequest.addr[31:28] == 4'hF) &&
		((prevRequest.addr[47:32] == 16'h0000) || (prevRequest.addr[47:32] == 16'hFFFF));
	assign translateOn = mmuEnable && !ioSpace;
	assign isTranslate = (prevRequest.opm == tlbPkg::OpLoad) ||
		(prevRequest.opm == tlbPkg::OpStore);

	assign flushAll = (request.opm == tlbPkg::OpInvtlb);
	assign writeIndex = heldIndex;
	assign clearEnable = writeEnable;
	assign clearIndex = heldIndex;

	always_comb
	begin
		nextState = state;
		writeEnable = 1'b0;
		writeSet = loadSet;
		nextResponse.addr = prevRequest.addr;
		nextResponse.opm = prevRequest.opm;
		nextResponse.ok = tlbPkg::OkReady;
		nextResponse.exc = tlbPkg::NoExc;

		if (isTranslate)
		begin
			if (translateOn)
			begin
				if (hit)
				begin
					nextResponse.addr = physAddr;
				end
				else
				begin
					nextResponse.addr = tlbPkg::MissAddr;
					if (pageReady)
					begin
						nextResponse.exc = tlbPkg::MissExc;
					end
				end
			end
			if (pageReady)
			begin
				nextResponse.ok = tlbPkg::OkOk;
			end
		end

		// one set write per held request
		case (state)
			Idle:
			begin
				if ((request.opm == tlbPkg::OpLdtlb) && pageReady)
				begin
					writeEnable = 1'b1;
					nextState = Loaded;
				end
				else if (isTranslate && translateOn && pageReady && hit && !hitWay[0])
				begin
					writeEnable = 1'b1;
					writeSet = reorderSet;
					nextState = Reordered;
				end
			end
			default:
			begin
				if (!sameRequest)
				begin
					nextState = Idle;
				end
			end
		endcase

		if (request.opm == tlbPkg::OpLdtlb)
		begin
			nextResponse.ok = ((state == Loaded) && sameRequest) ? tlbPkg::OkOk : tlbPkg::OkHold;
		end
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= Idle;
			prevRequest <= '0;
			response <= '{addr: '0, opm: tlbPkg::OpNone, ok: tlbPkg::OkReady,
				exc: tlbPkg::NoExc};
		end
		else
		begin
			state <= nextState;
			prevRequest <= request;
			response <= nextResponse;
		end
	end

endmodule

// ==== source/mmuTlb.sv ====
////////////////////
// TLB top level
// store, flush mask, matcher, controller
////////////////////
module mmuTlb
(
	input logic clock,
	input logic arstN,
	input tlbPkg::TlbRequest request,
	input logic mmuEnable,
	output tlbPkg::TlbResponse response
);

	tlbPkg::SetIndex readIndex;
	tlbPkg::SetIndex heldIndex;
	tlbPkg::SetIndex writeIndex;
	tlbPkg::SetIndex clearIndex;
	tlbPkg::TlbSet storedSet;
	tlbPkg::TlbSet writeSet;
	tlbPkg::TlbSet reorderSet;
	tlbPkg::TlbSet loadSet;
	tlbPkg::VirtAddr lookupAddr;
	tlbPkg::VirtAddr physAddr;
	logic [tlbPkg::WayCount-1:0] hitWay;
	logic hit;
	logic setFlushed;
	logic writeEnable;
	logic flushAll;
	logic clearEnable;

	tlbControl i_tlbControl (.clock, .arstN, .request, .mmuEnable, .heldIndex,
		.hitWay, .hit, .physAddr, .reorderSet, .loadSet, .readIndex, .lookupAddr,
		.writeEnable, .writeIndex, .writeSet, .flushAll, .clearEnable, .clearIndex,
		.response);

	tlbWayStore i_tlbWayStore (.clock, .arstN, .readIndex, .storedSet, .heldIndex,
		.writeEnable, .writeIndex, .writeSet);

	tlbFlushMask i_tlbFlushMask (.clock, .arstN, .flushAll, .clearEnable,
		.clearIndex, .heldIndex, .setFlushed);

	// new entry comes straight from the request data
	tlbWayMatch i_tlbWayMatch (.storedSet, .setFlushed, .lookupAddr,
		.newEntry(request.data), .hitWay, .hit, .physAddr, .reorderSet, .loadSet);

endmodule

// ==== testbench/tbClock.sv ====
////////////////////
// testbench clock and reset
////////////////////
module tbClock
#(
	parameter int Period = 40,
	parameter int ResetCycles = 3
)
(
	output logic clock,
	output logic arstN
);

	initial
	begin
		clock = 1'b0;
		forever #(Period / 2) clock = ~clock;
	end

	// reset released on a rising edge
	initial
	begin
		arstN = 1'b0;
		repeat (ResetCycles) @(posedge clock);
		arstN <= 1'b1;
	end

endmodule

// ==== testbench/tbTests.svh ====
////////////////////
// request drivers
// directed TLB tests
////////////////////

task automatic setMmu(input logic enable);
	@(posedge clock);
	mmuEnable <= enable;
	mmuOn = enable;
endtask

task automatic sendRequest(input tlbPkg::MemOp op, input tlbPkg::VirtAddr addr,
	input tlbPkg::TlbEntry data);
	@(posedge clock);
	request <= '{opm: op, addr: addr, data: data};
endtask

task automatic releaseRequest();
	@(posedge clock);
	request <= '0;
endtask

// request is held until ok reads OkOk
task automatic waitForOk(input string what);
	int waited;
	waited = 0;
	@(negedge clock);
	while (response.ok != tlbPkg::OkOk)
	begin
		if (waited == MaxWait)
		begin
			failRun($sformatf("%s got no OK response within %0d cycles", what, MaxWait));
		end
		waited++;
		@(negedge clock);
	end
	latency = waited;
	lastResponse = response;
endtask

task automatic translateCheck(input tlbPkg::MemOp op, input tlbPkg::VirtAddr addr);
	tlbPkg::VirtAddr expAddr;
	tlbPkg::ExcCode expExc;
	predictAccess(addr, expAddr, expExc);
	sendRequest(op, addr, '0);
	waitForOk("translation");
	checkLatency(latency, 2, "translation");
	checkOp(lastResponse.opm, op, "translation");
	checkAddr(lastResponse.addr, expAddr, "translated");
	checkExc(lastResponse.exc, expExc, "translation");
	releaseRequest();
endtask

// page ready after one edge, write on the next, OK one edge later
task automatic loadEntry(input tlbPkg::TlbEntry entry);
	sendRequest(tlbPkg::OpLdtlb, {entry.virtPage, 12'h000}, entry);
	waitForOk("LDTLB");
	checkLatency(latency, 3, "LDTLB");
	checkOp(lastResponse.opm, tlbPkg::OpLdtlb, "LDTLB");
	releaseRequest();
	recordLoad(entry);
endtask

task automatic resetAndBypass();
	tlbPkg::PageNum page;
	tlbPkg::VirtAddr addr;
	@(negedge clock);
	checkOk(response.ok, tlbPkg::OkReady, "reset");
	checkExc(response.exc, tlbPkg::NoExc, "reset");
	checkOp(response.opm, tlbPkg::OpNone, "reset");
	randomPage(page);
	addr = {page, 12'h3C4};
	translateCheck(tlbPkg::OpLoad, addr);
	checkAddr(lastResponse.addr, tlbPkg::MissAddr, "miss");
	checkExc(lastResponse.exc, tlbPkg::MissExc, "miss");
	setMmu(1'b0);
	translateCheck(tlbPkg::OpLoad, addr);
	checkAddr(lastResponse.addr, addr, "MMU off");
	setMmu(1'b1);
endtask

task automatic loadAndHit();
	tlbPkg::PageNum virtPage;
	tlbPkg::PageNum physPage;
	randomPage(virtPage);
	randomPage(physPage);
	loadEntry(makeEntry(virtPage, physPage));
	translateCheck(tlbPkg::OpLoad, {virtPage, 12'hABC});
	checkAddr(lastResponse.addr, {physPage, 12'hABC}, "hit");
	translateCheck(tlbPkg::OpStore, {virtPage, 12'h010});
endtask

// five entries into one set evict the first
task automatic setEviction();
	tlbPkg::PageNum pages [5];
	tlbPkg::PageNum base;
	tlbPkg::PageNum physPage;
	tlbPkg::SetIndex target;
	randomPage(base);
	target = base[15:10];
	for (int i = 0; i < 5; i++)
	begin
		randomPage(base);
		pages[i] = pageInSet(base, target);
		randomPage(physPage);
		loadEntry(makeEntry(pages[i], physPage));
	end
	for (int i = 0; i < 5; i++)
	begin
		translateCheck(tlbPkg::OpLoad, {pages[i], 12'h777});
		checkExc(lastResponse.exc, (i == 0) ? tlbPkg::MissExc : tlbPkg::NoExc, "same-set load");
	end
endtask

// hit on the oldest way moves it to the front
task automatic mruReorder();
	tlbPkg::PageNum pages [5];
	tlbPkg::PageNum base;
	tlbPkg::PageNum physPage;
	tlbPkg::SetIndex target;
	randomPage(base);
	target = base[13:8];
	for (int i = 0; i < 5; i++)
	begin
		randomPage(base);
		pages[i] = pageInSet(base, target);
	end
	for (int i = 0; i < 4; i++)
	begin
		randomPage(physPage);
		loadEntry(makeEntry(pages[i], physPage));
	end
	translateCheck(tlbPkg::OpLoad, {pages[0], 12'h100});
	randomPage(physPage);
	loadEntry(makeEntry(pages[4], physPage));
	for (int i = 0; i < 5; i++)
	begin
		translateCheck(tlbPkg::OpLoad, {pages[i], 12'h204});
		checkExc(lastResponse.exc, (i == 1) ? tlbPkg::MissExc : tlbPkg::NoExc, "after reorder");
	end
endtask

task automatic invalidateAll();
	sendRequest(tlbPkg::OpInvtlb, '0, '0);
	releaseRequest();
	repeat (2) @(negedge clock);
	checkOk(response.ok, tlbPkg::OkReady, "INVTLB");
	modelFlushed = '1;
	foreach (loadedPages[i])
	begin
		translateCheck(tlbPkg::OpLoad, {loadedPages[i], 12'h5A0});
		checkExc(lastResponse.exc, tlbPkg::MissExc, "flushed page");
	end
endtask

task automatic ioBypass();
	translateCheck(tlbPkg::OpLoad, 48'h0000F0001234);
	checkAddr(lastResponse.addr, 48'h0000F0001234, "I/O window");
	checkExc(lastResponse.exc, tlbPkg::NoExc, "I/O window");
	translateCheck(tlbPkg::OpStore, 48'hFFFFF00ABCDE);
endtask

// ==== testbench/tbMmuTlb.sv ====
////////////////////
// TLB testbench top
// DUT, clock, reference model
// compare tasks and watchdog
////////////////////
module tbMmuTlb;

	localparam int ClockPeriod = 40;
	localparam int ResetCycles = 3;
	localparam int MaxWait = 10;
	localparam int TestCount = 6;
	localparam int RequestsPerTest = 16;
	// each request needs its wait plus a release cycle
	localparam int WatchdogCycles = ResetCycles + TestCount * RequestsPerTest * (MaxWait + 2);

	logic clock;
	logic arstN;
	logic mmuEnable;
	tlbPkg::TlbRequest request;
	tlbPkg::TlbResponse response;

	// reference copy of the entry store
	tlbPkg::TlbSet modelSets [tlbPkg::SetCount];
	logic [tlbPkg::SetCount-1:0] modelFlushed;
	tlbPkg::PageNum loadedPages [$];
	logic mmuOn;
	integer seed;
	int latency;
	tlbPkg::TlbResponse lastResponse;

	tbClock #(.Period(ClockPeriod), .ResetCycles(ResetCycles)) i_tbClock (.clock, .arstN);

	mmuTlb i_mmuTlb (.clock, .arstN, .request, .mmuEnable, .response);

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkAddr(input tlbPkg::VirtAddr got, input tlbPkg::VirtAddr expected,
		input string what);
		if (got !== expected)
		begin
			failRun($sformatf("Error at time %0t: %s address %h, expected %h",
				$time, what, got, expected));
		end
	endtask

	task automatic checkExc(input tlbPkg::ExcCode got, input tlbPkg::ExcCode expected,
		input string what);
		if (got !== expected)
		begin
			failRun($sformatf("Error at time %0t: %s exception %h, expected %h",
				$time, what, got, expected));
		end
	endtask

	task automatic checkOk(input tlbPkg::OkCode got, input tlbPkg::OkCode expected,
		input string what);
		if (got !== expected)
		begin
			failRun($sformatf("Error at time %0t: %s ok code %s, expected %s",
				$time, what, got.name(), expected.name()));
		end
	endtask

	task automatic checkOp(input tlbPkg::MemOp got, input tlbPkg::MemOp expected,
		input string what);
		if (got !== expected)
		begin
			failRun($sformatf("Error at time %0t: %s op %s, expected %s",
				$time, what, got.name(), expected.name()));
		end
	endtask

	task automatic checkLatency(input int got, input int expected, input string what);
		if (got != expected)
		begin
			failRun($sformatf("Error at time %0t: %s answered after %0d edges, expected %0d",
				$time, what, got, expected));
		end
	endtask

	// set index from address bits 17..12 xor 21..16, in page bits
	function automatic tlbPkg::SetIndex setOfPage(input tlbPkg::PageNum page);
		return page[5:0] ^ page[9:4];
	endfunction

	function automatic logic inIoWindow(input tlbPkg::VirtAddr addr);
		return (&addr[31:28]) && ((addr[47:32] == '0) || (&addr[47:32]));
	endfunction

	// move a page into a set keeping bits 7..4
	function automatic tlbPkg::PageNum pageInSet(input tlbPkg::PageNum base,
		input tlbPkg::SetIndex target);
		tlbPkg::PageNum page;
		page = base;
		page[3:0] = target[3:0] ^ page[7:4];
		page[9:8] = target[5:4] ^ page[5:4];
		return page;
	endfunction

	function automatic tlbPkg::TlbEntry makeEntry(input tlbPkg::PageNum virtPage,
		input tlbPkg::PageNum physPage);
		return '{virtPage: virtPage, physPage: physPage, valid: 1'b1};
	endfunction

	task automatic randomPage(output tlbPkg::PageNum page);
		logic [63:0] raw;
		raw = {$random(seed), $random(seed)};
		page = raw[tlbPkg::VirtWidth-tlbPkg::PageShift-1:0];
		// stay out of the I/O window
		page[19] = 1'b0;
	endtask

	// expected response and the MRU move on a hit
	task automatic predictAccess(input tlbPkg::VirtAddr addr, output tlbPkg::VirtAddr expAddr,
		output tlbPkg::ExcCode expExc);
		tlbPkg::SetIndex idx;
		tlbPkg::TlbEntry found;
		int hitAt;
		idx = setOfPage(addr[tlbPkg::VirtWidth-1:tlbPkg::PageShift]);
		expAddr = addr;
		expExc = tlbPkg::NoExc;
		hitAt = -1;
		if (mmuOn && !inIoWindow(addr) && !modelFlushed[idx])
		begin
			for (int w = 0; w < tlbPkg::WayCount; w++)
			begin
				if (hitAt < 0 && modelSets[idx][w].valid &&
					modelSets[idx][w].virtPage == addr[tlbPkg::VirtWidth-1:tlbPkg::PageShift])
				begin
					hitAt = w;
				end
			end
		end
		if (mmuOn && !inIoWindow(addr))
		begin
			if (hitAt < 0)
			begin
				expAddr = tlbPkg::MissAddr;
				expExc = tlbPkg::MissExc;
			end
			else
			begin
				found = modelSets[idx][hitAt];
				expAddr = {found.physPage, addr[tlbPkg::PageShift-1:0]};
				for (int w = hitAt; w > 0; w--)
				begin
					modelSets[idx][w] = modelSets[idx][w-1];
				end
				modelSets[idx][0] = found;
			end
		end
	endtask

	// insert at way 0 so way 3 drops out
	task automatic recordLoad(input tlbPkg::TlbEntry entry);
		tlbPkg::SetIndex idx;
		idx = setOfPage(entry.virtPage);
		// a flushed set keeps no valid way
		if (modelFlushed[idx])
		begin
			for (int w = 0; w < tlbPkg::WayCount; w++)
			begin
				modelSets[idx][w].valid = 1'b0;
			end
		end
		for (int w = tlbPkg::WayCount - 1; w > 0; w--)
		begin
			modelSets[idx][w] = modelSets[idx][w-1];
		end
		modelSets[idx][0] = entry;
		modelFlushed[idx] = 1'b0;
		loadedPages.push_back(entry.virtPage);
	endtask

	`include "tbTests.svh"

	initial
	begin
		#(WatchdogCycles * ClockPeriod);
		$display("Watchdog expired after %0d cycles, a test is stuck", WatchdogCycles);
		$display("SIMULATION FAILED");
		$fatal(1, "timeout");
	end

	initial
	begin
		seed = 26;
		request = '0;
		mmuEnable = 1'b1;
		mmuOn = 1'b1;
		latency = 0;
		lastResponse = '0;
		modelFlushed = '1;
		foreach (modelSets[i])
		begin
			modelSets[i] = '0;
		end
		@(posedge arstN);
		resetAndBypass();
		loadAndHit();
		setEviction();
		mruReorder();
		invalidateAll();
		ioBypass();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+testbench
source/tlbPkg.sv
source/tlbWayStore.sv
source/tlbFlushMask.sv
source/tlbWayMatch.sv
source/tlbControl.sv
source/mmuTlb.sv
testbench/tbClock.sv
testbench/tbMmuTlb.sv

// ==== run.sh ====
#!/bin/sh
# build the TLB testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f tb.f --top-module tbMmuTlb || { echo "build failed"; exit 1; }
output=$(./obj_dir/VtbMmuTlb 2>&1)
echo "$output"
echo "$output" | grep -q "^SIMULATION PASSED$" && echo "run passed" || { echo "run failed"; exit 1; }
